// ==== verilog/frontend_pkg.sv ====
// Front end shared definitions
`default_nettype none

package frontend_pkg;

    typedef logic [63:0] inst_t;     // Instruction window or canonical instruction
    typedef logic [63:0] word_t;     // Wishbone data word
    typedef logic [5:0]  reg_num_t;
    typedef logic [2:0]  unit_t;
    typedef logic [1:0]  op_t;
    typedef logic [55:0] imm_t;
    typedef logic [4:0]  byte_cnt_t; // 0 to 16 buffered bytes

    // Byte sizes
    localparam byte_cnt_t WORD_BYTES  = 5'd8;
    localparam byte_cnt_t BUF_BYTES   = 5'd16;
    localparam byte_cnt_t LEN16_BYTES = 5'd2;
    localparam byte_cnt_t LEN32_BYTES = 5'd4;
    localparam byte_cnt_t LEN64_BYTES = 5'd8;

    // Length tags in the top two bits
    localparam logic [1:0] TAG_32 = 2'b10;
    localparam logic [1:0] TAG_64 = 2'b11; // Also marks the canonical form

    localparam unit_t LAST_ALU_UNIT = 3'd4;
    localparam unit_t UNIT_UPPER    = 3'd5; // Op 0 is LUI, no source register
    localparam unit_t UNIT_STORE    = 3'd6;
    localparam unit_t UNIT_JUMP     = 3'd7;

endpackage

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
// Wishbone instruction fetch master
`default_nettype none

module fetch_unit #(
    parameter int                ADDR_W    = 16,
    parameter logic [ADDR_W-1:0] BOOT_ADDR = '0
) (
    input  wire                       clk,
    input  wire                       rst_n,

    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic [ADDR_W-1:0]         wb_adr,
    input  wire                       wb_ack,
    input  wire frontend_pkg::word_t  wb_rdata,

    input  wire frontend_pkg::byte_cnt_t byte_count,
    output logic                      push,
    output frontend_pkg::word_t       push_data
);
    import frontend_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_REQUEST
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic [ADDR_W-1:0] addr_q;
    logic              room_now;   // Space for one more word
    logic              room_after; // Space behind the word arriving now

    assign room_now   = byte_count <= WORD_BYTES;
    assign room_after = (byte_count + WORD_BYTES) <= WORD_BYTES;

    // Bus cycle spans the whole request state
    assign wb_cyc = (state_q == ST_REQUEST);
    assign wb_stb = (state_q == ST_REQUEST);
    assign wb_adr = addr_q;

    assign push      = (state_q == ST_REQUEST) && wb_ack;
    assign push_data = wb_rdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (room_now) begin
                    state_d = ST_REQUEST;
                end
            end
            ST_REQUEST: begin
                if (wb_ack && !room_after) begin
                    state_d = ST_IDLE; // Drop stb for at least a cycle
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            addr_q  <= BOOT_ADDR;
        end else begin
            state_q <= state_d;
            if (push) begin
                addr_q <= addr_q + ADDR_W'(WORD_BYTES); // Sequential words only
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/inst_align.sv ====
// Instruction alignment buffer
`default_nettype none

module inst_align (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire                       push,
    input  wire frontend_pkg::word_t  push_data,

    input  wire                       advance16,
    input  wire                       advance32,
    input  wire                       advance64,

    output frontend_pkg::inst_t       window,
    output frontend_pkg::byte_cnt_t   byte_count
);
    import frontend_pkg::*;

    localparam int BUF_W  = BUF_BYTES * 8;
    localparam int WORD_W = $bits(word_t);

    logic [BUF_W-1:0] buf_q;    // Oldest byte in the top lane
    logic [BUF_W-1:0] kept;
    logic [BUF_W-1:0] incoming;
    byte_cnt_t        count_q;
    byte_cnt_t        drop;
    byte_cnt_t        remain;

    // Consumed bytes this cycle
    always_comb begin
        drop = '0;
        if (advance16) begin
            drop = LEN16_BYTES;
        end else if (advance32) begin
            drop = LEN32_BYTES;
        end else if (advance64) begin
            drop = LEN64_BYTES;
        end
    end

    assign remain = count_q - drop;
    assign kept   = buf_q << {drop, 3'b000}; // Zeros fill the free lanes

    // New word lands right behind what is left
    always_comb begin
        incoming = '0;
        if (push) begin
            incoming = {push_data, {(BUF_W - WORD_W){1'b0}}} >> {remain, 3'b000};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_q   <= '0;
            count_q <= '0;
        end else begin
            buf_q   <= kept | incoming;
            count_q <= remain + (push ? WORD_BYTES : byte_cnt_t'(0));
        end
    end

    assign window     = buf_q[BUF_W-1 -: $bits(inst_t)];
    assign byte_count = count_q;

endmodule

`default_nettype wire

// ==== verilog/de_canonicalize.sv ====
// Short form expansion to canonical
`default_nettype none

module de_canonicalize (
    input  wire frontend_pkg::inst_t inst_in,
    output frontend_pkg::inst_t      inst_out
);
    import frontend_pkg::*;

    always_comb begin
        inst_out = '0;
        if (!inst_in[63]) begin // 16-bit form
            inst_out[63:62] = TAG_64;
            inst_out[61]    = inst_in[62];             // Type
            inst_out[60:58] = inst_in[61:59];          // Unit
            inst_out[57:56] = {1'b0, inst_in[58]};     // Op high bit is 0
            inst_out[55:50] = {2'b00, inst_in[57:54]}; // rd
            inst_out[43:38] = {2'b00, inst_in[57:54]}; // rs1 is the same register
            if (inst_in[62]) begin
                inst_out[37:0] = {{34{inst_in[53]}}, inst_in[53:50]};
            end else begin
                inst_out[37:32] = {2'b00, inst_in[53:50]};
            end
        end else if (inst_in[63:62] == TAG_32) begin
            inst_out[63:62] = TAG_64;
            inst_out[61:56] = inst_in[61:56]; // Header kept
            inst_out[55:50] = inst_in[55:50];
            inst_out[43:38] = inst_in[49:44];
            // rd2 stays zero in both types
            if (inst_in[61]) begin
                inst_out[37:0] = {{26{inst_in[43]}}, inst_in[43:32]}; // 12-bit immediate
            end else begin
                inst_out[37:32] = inst_in[43:38];
            end
        end else begin
            inst_out = inst_in; // Already canonical
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decode.sv ====
// Instruction decode stage
`default_nettype none

module decode (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire frontend_pkg::inst_t    window,
    input  wire frontend_pkg::byte_cnt_t byte_count,
    input  wire                         allow_advance,

    output logic                        advance16,
    output logic                        advance32,
    output logic                        advance64,

    output logic                        dec_valid,
    output logic                        inst_type,
    output logic                        illegal,
    output frontend_pkg::unit_t         unit,
    output frontend_pkg::op_t           op,
    output frontend_pkg::reg_num_t      rs1_rn,
    output frontend_pkg::reg_num_t      rs2_rn,
    output frontend_pkg::reg_num_t      rd_rn,
    output frontend_pkg::reg_num_t      rd2_rn,
    output frontend_pkg::reg_num_t      r1_rn,
    output frontend_pkg::reg_num_t      r2_rn,
    output frontend_pkg::imm_t          imm_data
);
    import frontend_pkg::*;

    inst_t canon;
    logic  is16;
    logic  is32;
    logic  is64;
    logic  adv_any;
    logic  c_type;
    unit_t c_unit;
    op_t   c_op;
    logic  load_rs1;
    logic  load_rs1_rs2;
    logic  load_rs1_rd;
    logic  bad_op;

    de_canonicalize u_canon (
        .inst_in  (window),
        .inst_out (canon)
    );

    // Length from the top bits of the window
    assign is16 = !window[63];
    assign is32 = (window[63:62] == TAG_32);
    assign is64 = (window[63:62] == TAG_64);

    // Only advance once the whole instruction is buffered
    assign advance16 = allow_advance && is16 && (byte_count >= LEN16_BYTES);
    assign advance32 = allow_advance && is32 && (byte_count >= LEN32_BYTES);
    assign advance64 = allow_advance && is64 && (byte_count >= LEN64_BYTES);
    assign adv_any   = advance16 || advance32 || advance64;

    assign c_type = canon[61];
    assign c_unit = canon[60:58];
    assign c_op   = canon[57:56];

    always_comb begin
        load_rs1     = 1'b0;
        load_rs1_rs2 = 1'b0;
        load_rs1_rd  = 1'b0;
        if (!c_type) begin // R-type
            if (c_unit <= LAST_ALU_UNIT || (c_unit == UNIT_JUMP && c_op == 2'd1)) begin
                load_rs1_rs2 = 1'b1;
            end else if (c_unit == UNIT_JUMP && c_op[1]) begin
                load_rs1 = 1'b1; // Register jumps
            end
        end else begin
            if (c_unit <= LAST_ALU_UNIT || (c_unit == UNIT_UPPER && c_op != 2'd0)) begin
                load_rs1 = 1'b1;
            end else if (c_unit == UNIT_STORE || (c_unit == UNIT_JUMP && !c_op[1])) begin
                load_rs1_rd = 1'b1; // Stores and compare branches
            end
        end
    end

    assign bad_op = (is16 && c_unit == UNIT_JUMP) || (!c_type && c_unit == UNIT_STORE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            inst_type <= 1'b0;
            illegal   <= 1'b0;
            unit      <= '0;
            op        <= '0;
            rs1_rn    <= '0;
            rs2_rn    <= '0;
            rd_rn     <= '0;
            rd2_rn    <= '0;
            r1_rn     <= '0;
            r2_rn     <= '0;
            imm_data  <= '0;
        end else begin
            dec_valid <= adv_any;
            if (adv_any) begin
                inst_type <= c_type;
                illegal   <= bad_op;
                unit      <= c_unit;
                op        <= c_op;
                rs1_rn    <= canon[43:38];
                rs2_rn    <= canon[37:32];
                rd_rn     <= canon[55:50];
                rd2_rn    <= canon[49:44];
                imm_data  <= canon[55:0];
                r1_rn     <= (load_rs1 || load_rs1_rs2 || load_rs1_rd) ? canon[43:38] : '0;
                r2_rn     <= load_rs1_rd  ? canon[55:50] :
                             load_rs1_rs2 ? canon[37:32] : '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frontend_top.sv ====
// Instruction front end top level
`default_nettype none

module frontend_top #(
    parameter int                ADDR_W    = 16,
    parameter logic [ADDR_W-1:0] BOOT_ADDR = '0
) (
    input  wire                       clk,
    input  wire                       rst_n,

    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic [ADDR_W-1:0]         wb_adr,
    input  wire                       wb_ack,
    input  wire frontend_pkg::word_t  wb_rdata,

    input  wire                       allow_advance,

    output logic                      dec_valid,
    output logic                      inst_type,
    output logic                      illegal,
    output frontend_pkg::unit_t       unit,
    output frontend_pkg::op_t         op,
    output frontend_pkg::reg_num_t    rs1_rn,
    output frontend_pkg::reg_num_t    rs2_rn,
    output frontend_pkg::reg_num_t    rd_rn,
    output frontend_pkg::reg_num_t    rd2_rn,
    output frontend_pkg::reg_num_t    r1_rn,
    output frontend_pkg::reg_num_t    r2_rn,
    output frontend_pkg::imm_t        imm_data
);
    import frontend_pkg::*;

    logic      push;
    word_t     push_data;
    byte_cnt_t byte_count;
    inst_t     window;
    logic      advance16;
    logic      advance32;
    logic      advance64;

    fetch_unit #(
        .ADDR_W    (ADDR_W),
        .BOOT_ADDR (BOOT_ADDR)
    ) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_ack     (wb_ack),
        .wb_rdata   (wb_rdata),
        .byte_count (byte_count),
        .push       (push),
        .push_data  (push_data)
    );

    inst_align u_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_data  (push_data),
        .advance16  (advance16),
        .advance32  (advance32),
        .advance64  (advance64),
        .window     (window),
        .byte_count (byte_count)
    );

    decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .window        (window),
        .byte_count    (byte_count),
        .allow_advance (allow_advance),
        .advance16     (advance16),
        .advance32     (advance32),
        .advance64     (advance64),
        .dec_valid     (dec_valid),
        .inst_type     (inst_type),
        .illegal       (illegal),
        .unit          (unit),
        .op            (op),
        .rs1_rn        (rs1_rn),
        .rs2_rn        (rs2_rn),
        .rd_rn         (rd_rn),
        .rd2_rn        (rd2_rn),
        .r1_rn         (r1_rn),
        .r2_rn         (r2_rn),
        .imm_data      (imm_data)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Testbench clock and reset
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // Released on a rising edge
    end

endmodule

`default_nettype wire

// ==== tests/tb_wb_memory.sv ====
// Wishbone slave memory model
`default_nettype none

module tb_wb_memory #(
    parameter int ADDR_W = 16
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              wb_cyc,
    input  wire              wb_stb,
    input  wire [ADDR_W-1:0] wb_adr,
    input  wire              random_waits,
    output logic             wb_ack,
    output logic [63:0]      wb_rdata
);
    localparam int DEPTH = 1 << (ADDR_W - 3);

    logic [63:0] mem [0:DEPTH-1]; // Loaded by the testbench
    logic [1:0]  wait_left;
    integer      seed;

    initial seed = 32'hba65_8a46;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            wb_rdata  <= '0;
            wait_left <= 2'd0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (wait_left == 2'd0) begin
                    wb_ack    <= 1'b1;
                    wb_rdata  <= mem[wb_adr[ADDR_W-1:3]];
                    wait_left <= random_waits ? 2'($random(seed)) : 2'd0; // Next access
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_frontend.sv ====
// Front end testbench
`default_nettype none

module tb_frontend;
    import frontend_pkg::*;

    localparam int                ADDR_W    = 16;
    localparam logic [ADDR_W-1:0] BOOT_ADDR = 16'h0040;

    logic              clk;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic [ADDR_W-1:0] wb_adr;
    logic              wb_ack;
    word_t             wb_rdata;
    logic              allow_advance;
    logic              random_waits;
    logic              dec_valid;
    logic              inst_type;
    logic              illegal;
    unit_t             unit;
    op_t               op;
    reg_num_t          rs1_rn;
    reg_num_t          rs2_rn;
    reg_num_t          rd_rn;
    reg_num_t          rd2_rn;
    reg_num_t          r1_rn;
    reg_num_t          r2_rn;
    imm_t              imm_data;

    logic [7:0]        prog [$];      // Program bytes in fetch order
    inst_t             exp_canon [$];
    int                exp_len [$];
    int                out_idx = 0;
    int                errors = 0;
    int                max_fill = 0;
    logic              last_allow = 1'b0;
    logic              last_stb = 1'b0;
    logic              last_ack = 1'b0;
    logic [ADDR_W-1:0] exp_adr = BOOT_ADDR;
    logic              built = 1'b0;
    integer            seed = 32'hba65_8a46;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(2)) u_clock (.clk(clk), .rst_n(rst_n));

    tb_wb_memory #(.ADDR_W(ADDR_W)) u_mem (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .random_waits(random_waits), .wb_ack(wb_ack), .wb_rdata(wb_rdata)
    );

    frontend_top #(.ADDR_W(ADDR_W), .BOOT_ADDR(BOOT_ADDR)) uut (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_ack(wb_ack), .wb_rdata(wb_rdata), .allow_advance(allow_advance),
        .dec_valid(dec_valid), .inst_type(inst_type), .illegal(illegal), .unit(unit),
        .op(op), .rs1_rn(rs1_rn), .rs2_rn(rs2_rn), .rd_rn(rd_rn), .rd2_rn(rd2_rn),
        .r1_rn(r1_rn), .r2_rn(r2_rn), .imm_data(imm_data)
    );

    // Canonical form of a left-aligned instruction
    function automatic inst_t expand(input int len, input inst_t raw);
        inst_t c;
        c = '0;
        if (len == 16) begin
            c[63:56] = {2'b11, raw[62], raw[61:59], 1'b0, raw[58]};
            c[53:50] = raw[57:54];
            c[41:38] = raw[57:54];
            if (raw[62]) begin
                c[37:0] = 38'($signed(raw[53:50]));
            end else begin
                c[35:32] = raw[53:50];
            end
        end else if (len == 32) begin
            c[63:50] = {2'b11, raw[61:50]};
            c[43:38] = raw[49:44];
            if (raw[61]) begin
                c[37:0] = 38'($signed(raw[43:32]));
            end else begin
                c[37:32] = raw[43:38];
            end
        end else begin
            c = raw;
        end
        return c;
    endfunction

    function automatic inst_t random_word();
        return {$random(seed), $random(seed)};
    endfunction

    // Header plus random body, tag chosen by length
    function automatic inst_t make_inst(input int len, input logic t, input unit_t u,
                                        input op_t o);
        inst_t r;
        r = random_word();
        if (len == 16) begin
            r[63:58] = {1'b0, t, u, o[0]};
        end else begin
            r[63:56] = {(len == 32) ? 2'b10 : 2'b11, t, u, o};
        end
        return r;
    endfunction

    task automatic add_inst(input int len, input inst_t raw);
        for (int i = 0; i < len / 8; i++) begin
            prog.push_back(raw[63 - 8 * i -: 8]);
        end
        exp_canon.push_back(expand(len, raw));
        exp_len.push_back(len);
    endtask

    task automatic add_random(input int len);
        inst_t r;
        r = random_word();
        add_inst(len, make_inst(len, r[0], r[3:1], r[5:4]));
    endtask

    task automatic add_mixed(input int count);
        int pick;
        for (int i = 0; i < count; i++) begin
            pick = $unsigned($random(seed)) % 3;
            add_random((pick == 0) ? 16 : (pick == 1) ? 32 : 64);
        end
    endtask

    task automatic add_table();
        for (int len = 16; len <= 64; len = len * 2) begin
            for (int t = 0; t < 2; t++) begin
                for (int u = 0; u < 8; u++) begin
                    for (int o = 0; o < ((len == 16) ? 2 : 4); o++) begin
                        add_inst(len, make_inst(len, 1'(t), 3'(u), 2'(o)));
                    end
                end
            end
        end
    endtask

    task automatic load_memory();
        logic [63:0] w;
        for (int a = 0; a < (1 << (ADDR_W - 3)); a++) begin
            u_mem.mem[a] = {4{16'(a) ^ 16'hc3a5}};
        end
        while (prog.size() % 8 != 0) begin
            prog.push_back(8'h00);
        end
        for (int i = 0; i < prog.size() / 8; i++) begin
            for (int b = 0; b < 8; b++) begin
                w[63 - 8 * b -: 8] = prog[8 * i + b];
            end
            u_mem.mem[int'(BOOT_ADDR >> 3) + i] = w;
        end
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h at instruction %0d",
                     name, got, exp, out_idx);
            errors++;
        end
    endtask

    task automatic check_outputs(input inst_t c, input int len);
        logic     t;
        unit_t    u;
        op_t      o;
        logic     both;
        logic     only1;
        logic     with_rd;
        reg_num_t e_r1;
        reg_num_t e_r2;
        t = c[61];
        u = c[60:58];
        o = c[57:56];
        both    = !t && (u <= 3'd4 || (u == 3'd7 && o == 2'd1));
        only1   = (!t && u == 3'd7 && o >= 2'd2) || (t && (u <= 3'd4 || (u == 3'd5 && o != 2'd0)));
        with_rd = t && (u == 3'd6 || (u == 3'd7 && o <= 2'd1));
        e_r1 = (both || only1 || with_rd) ? c[43:38] : 6'd0;
        e_r2 = with_rd ? c[55:50] : (both ? c[37:32] : 6'd0);
        compare("inst_type", 64'(inst_type), 64'(t));
        compare("unit", 64'(unit), 64'(u));
        compare("op", 64'(op), 64'(o));
        compare("rd_rn", 64'(rd_rn), 64'(c[55:50]));
        compare("rd2_rn", 64'(rd2_rn), 64'(c[49:44]));
        compare("rs1_rn", 64'(rs1_rn), 64'(c[43:38]));
        compare("rs2_rn", 64'(rs2_rn), 64'(c[37:32]));
        compare("imm_data", 64'(imm_data), 64'(c[55:0]));
        compare("r1_rn", 64'(r1_rn), 64'(e_r1));
        compare("r2_rn", 64'(r2_rn), 64'(e_r2));
        compare("illegal", 64'(illegal), 64'((len == 16 && u == 3'd7) || (!t && u == 3'd6)));
    endtask

    // Output and bus monitor, sampled before the edge updates
    always @(posedge clk) begin
        if (rst_n) begin
            if (dec_valid) begin
                if (!last_allow) begin
                    $display("dec_valid rose after a cycle with allow_advance low");
                    errors++;
                end
                if (out_idx >= exp_canon.size()) begin
                    $display("More instructions decoded than the program holds");
                    errors++;
                end else begin
                    check_outputs(exp_canon[out_idx], exp_len[out_idx]);
                end
                out_idx++;
            end
            if (wb_stb && (!last_stb || last_ack)) begin // New request
                if (uut.byte_count > 5'd8) begin
                    $display("Fetch requested with %0d bytes already buffered", uut.byte_count);
                    errors++;
                end
                compare("wb_adr", 64'(wb_adr), 64'(exp_adr));
            end
            if (wb_stb && wb_ack) begin
                exp_adr = exp_adr + 16'd8;
            end
        end
        if (int'(uut.byte_count) > max_fill) max_fill = int'(uut.byte_count);
        last_allow = allow_advance;
        last_stb   = wb_stb;
        last_ack   = wb_ack;
    end

    task automatic check_reset();
        wait (rst_n);
        #1;
        compare("wb_cyc", 64'(wb_cyc), 64'd0);
        compare("wb_stb", 64'(wb_stb), 64'd0);
        compare("dec_valid", 64'(dec_valid), 64'd0);
        compare("fields", 64'({inst_type, illegal, unit, op, rs1_rn, rs2_rn, rd_rn, rd2_rn,
                               r1_rn, r2_rn}), 64'd0);
        compare("imm_data", 64'(imm_data), 64'd0);
        while (!wb_stb) @(posedge clk);
        compare("wb_adr", 64'(wb_adr), 64'(BOOT_ADDR));
    endtask

    task automatic run_until(input int target);
        @(posedge clk);
        allow_advance <= 1'b1;
        while (out_idx < target) @(posedge clk);
        allow_advance <= 1'b0;
    endtask

    task automatic run_backpressure(input int target);
        int   stretch;
        logic level;
        level    = 1'b0;
        max_fill = 0;
        @(posedge clk);
        while (out_idx < target) begin
            stretch = level ? 1 + $unsigned($random(seed)) % 6 : 8 + $unsigned($random(seed)) % 10;
            allow_advance <= level;
            repeat (stretch) @(posedge clk);
            level = ~level;
        end
        allow_advance <= 1'b0;
        if (max_fill < 9) begin
            $display("Buffer never filled past 8 bytes under back-pressure");
            errors++;
        end
    endtask

    initial begin
        int end_stream;
        int end_mixed;
        int end_press;
        int end_table;
        allow_advance = 1'b0;
        random_waits  = 1'b0;
        for (int i = 0; i < 12; i++) add_random(64);
        end_stream = exp_canon.size();
        add_mixed(40);
        end_mixed = exp_canon.size();
        add_mixed(40);
        end_press = exp_canon.size();
        add_table();
        end_table = exp_canon.size();
        for (int i = 0; i < 8; i++) add_random(64); // Tail runs past the last check
        load_memory();
        built = 1'b1;

        check_reset();
        run_until(end_stream);
        random_waits <= 1'b1;
        run_until(end_mixed);
        run_backpressure(end_press);
        run_until(end_table);
        repeat (4) @(posedge clk);
        $display("Decoded %0d instructions, %0d errors", out_idx, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (built);
        repeat (200 * exp_canon.size()) @(posedge clk);
        $display("Timeout with %0d of %0d instructions decoded", out_idx, exp_canon.size());
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/frontend_pkg.sv
verilog/fetch_unit.sv
verilog/inst_align.sv
verilog/de_canonicalize.sv
verilog/decode.sv
verilog/frontend_top.sv
tests/tb_clock.sv
tests/tb_wb_memory.sv
tests/tb_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_frontend -Mdir obj_dir -o sim_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
